// File: hdl/mbd_settings.svh
`ifndef MBD_SETTINGS_SVH
`define MBD_SETTINGS_SVH

// VP8 cost model field widths
`define MBD_LAMBDA_W     16
`define MBD_RATE_W       16
`define MBD_DISTO_W      24
`define MBD_SCORE_W      40
`define MBD_POS_W        10

// Non-zero flag maps
`define MBD_YNZ_W        25
`define MBD_NZ4_W        16
`define MBD_UVNZ_W       8

// Distortion weight is 2**MBD_DISTO_SHIFT
`define MBD_DISTO_SHIFT  8

// One rate bit per multiplier step
`define MBD_MUL_STEPS    16

// Execute FSM state encoding width
`define MBD_STATE_W      2

`endif

// File: hdl/mbd_data_pkg.sv
`include "mbd_settings.svh"

package mbd_data_pkg;

    // ------------------------------------------------------------------
    // Candidates from the prediction stages
    // ------------------------------------------------------------------

    // Whole-block I16 candidate
    // ynz bit 24 is the Y2 DC flag, bits 15..0 the luma flags
    typedef struct packed {
        logic [`MBD_DISTO_W-1:0] disto;
        logic [`MBD_RATE_W-1:0]  rate;
        logic [`MBD_YNZ_W-1:0]   ynz;
    } cand16_t;

    // Sixteen-subblock I4 candidate
    typedef struct packed {
        logic [`MBD_DISTO_W-1:0] disto;
        logic [`MBD_RATE_W-1:0]  rate;
        logic [`MBD_NZ4_W-1:0]   ynz4;
    } cand4_t;

    // ------------------------------------------------------------------
    // Internal and output records
    // ------------------------------------------------------------------

    // One macroblock decision in flight
    typedef struct packed {
        logic [`MBD_POS_W-1:0]    x;
        logic [`MBD_POS_W-1:0]    y;
        logic [`MBD_LAMBDA_W-1:0] lambda;
        cand16_t                  c16;
        cand4_t                   c4;
        logic [`MBD_UVNZ_W-1:0]   uvnz;
    } mb_job_t;

    typedef struct packed {
        logic [`MBD_SCORE_W-1:0] score_i16;
        logic [`MBD_SCORE_W-1:0] score_i4;
    } mb_scores_t;

    // mb_type carries the mb_type_e encoding, 1 for I16
    typedef struct packed {
        logic [`MBD_POS_W-1:0]   x;
        logic [`MBD_POS_W-1:0]   y;
        logic                    mb_type;
        logic [`MBD_YNZ_W-1:0]   nz;
        logic                    skipped;
        logic [`MBD_SCORE_W-1:0] score;
    } mb_result_t;

endpackage

// File: hdl/mbd_ctrl_pkg.sv
`include "mbd_settings.svh"

package mbd_ctrl_pkg;

    // Execute FSM
    typedef enum logic [`MBD_STATE_W-1:0] {
        EX_IDLE = 2'd0,
        EX_MUL  = 2'd1,
        EX_SUM  = 2'd2
    } exec_state_e;

    // Macroblock type as coded in the VP8 header
    typedef enum logic {
        MB_I4  = 1'b0,
        MB_I16 = 1'b1
    } mb_type_e;

endpackage

// File: hdl/mbd_decode.sv
`timescale 1ns/1ps

`include "mbd_settings.svh"

module mbd_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reload,
    input  logic [`MBD_LAMBDA_W-1:0] lambda_in,
    input  logic                     start,
    input  logic [`MBD_POS_W-1:0]    x,
    input  logic [`MBD_POS_W-1:0]    y,
    input  mbd_data_pkg::cand16_t    cand16,
    input  mbd_data_pkg::cand4_t     cand4,
    input  logic [`MBD_UVNZ_W-1:0]   uvnz,
    input  logic                     exec_busy,
    output mbd_data_pkg::mb_job_t    job,
    output logic                     job_valid
);

    // Keeps the DC flag and the luma flags of the I16 map
    localparam logic [`MBD_YNZ_W-1:0] YNZ_MASK = {1'b1, 8'h00, 16'hffff};

    logic [`MBD_LAMBDA_W-1:0] lambda_q;
    logic                     accept;

    // ------------------------------------------------------------------
    // Lambda register
    // ------------------------------------------------------------------

    // A reload on the same edge as start only affects later jobs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lambda_q <= '0;
        end else if (reload) begin
            lambda_q <= lambda_in;
        end
    end

    // ------------------------------------------------------------------
    // Start qualification and capture
    // ------------------------------------------------------------------

    // Also blocks the edge where execute has not yet raised busy
    assign accept = start && !exec_busy && !job_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            job.x        <= x;
            job.y        <= y;
            job.lambda   <= lambda_q;
            job.c16.disto <= cand16.disto;
            job.c16.rate  <= cand16.rate;
            // Unused bits between DC and luma flags are cleared
            job.c16.ynz   <= cand16.ynz & YNZ_MASK;
            job.c4       <= cand4;
            job.uvnz     <= uvnz;
        end
    end

endmodule

// File: hdl/mbd_score_exec.sv
`timescale 1ns/1ps

`include "mbd_settings.svh"

module mbd_score_exec (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mbd_data_pkg::mb_job_t      job,
    input  logic                       job_valid,
    output logic                       exec_busy,
    output mbd_data_pkg::mb_scores_t   scores,
    output mbd_data_pkg::mb_job_t      job_out,
    output logic                       scores_valid
);

    localparam int SCORE_W = `MBD_SCORE_W;
    localparam int CNT_W   = $clog2(`MBD_MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MBD_MUL_STEPS - 1);

    mbd_ctrl_pkg::exec_state_e state;
    logic [CNT_W-1:0]          step_cnt;

    mbd_data_pkg::mb_job_t     job_q;
    logic [SCORE_W-1:0]        mcand;
    logic [SCORE_W-1:0]        acc16;
    logic [SCORE_W-1:0]        acc4;
    logic [`MBD_RATE_W-1:0]    rate16_sh;
    logic [`MBD_RATE_W-1:0]    rate4_sh;

    // One shift-add step, adds the current multiplicand on a set rate bit
    function automatic logic [SCORE_W-1:0] mul_step(input logic [SCORE_W-1:0] acc,
                                                    input logic [SCORE_W-1:0] m,
                                                    input logic           rbit);
        mul_step = rbit ? acc + m : acc;
    endfunction

    function automatic logic [SCORE_W-1:0] disto_term(input logic [`MBD_DISTO_W-1:0] d);
        disto_term = SCORE_W'(d) << `MBD_DISTO_SHIFT;
    endfunction

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= mbd_ctrl_pkg::EX_IDLE;
            step_cnt     <= '0;
            scores_valid <= 1'b0;
        end else begin
            case (state)
                mbd_ctrl_pkg::EX_IDLE: begin
                    if (job_valid) begin
                        // Step 0 runs on the capture edge
                        state    <= mbd_ctrl_pkg::EX_MUL;
                        step_cnt <= CNT_W'(1);
                    end
                end
                mbd_ctrl_pkg::EX_MUL: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_STEP) begin
                        state <= mbd_ctrl_pkg::EX_SUM;
                    end
                end
                mbd_ctrl_pkg::EX_SUM: begin
                    // First edge sums, second edge hands off and frees the unit
                    if (!scores_valid) begin
                        scores_valid <= 1'b1;
                    end else begin
                        scores_valid <= 1'b0;
                        state        <= mbd_ctrl_pkg::EX_IDLE;
                    end
                end
                default: begin
                    state <= mbd_ctrl_pkg::EX_IDLE;
                end
            endcase
        end
    end

    assign exec_busy = (state != mbd_ctrl_pkg::EX_IDLE);

    // ------------------------------------------------------------------
    // Multipliers and distortion adders
    // ------------------------------------------------------------------

    // Both multipliers share the shifted lambda
    always_ff @(posedge clk) begin
        if (state == mbd_ctrl_pkg::EX_IDLE && job_valid) begin
            job_q     <= job;
            acc16     <= mul_step('0, SCORE_W'(job.lambda), job.c16.rate[0]);
            acc4      <= mul_step('0, SCORE_W'(job.lambda), job.c4.rate[0]);
            rate16_sh <= job.c16.rate >> 1;
            rate4_sh  <= job.c4.rate >> 1;
            mcand     <= SCORE_W'(job.lambda) << 1;
        end else if (state == mbd_ctrl_pkg::EX_MUL) begin
            acc16     <= mul_step(acc16, mcand, rate16_sh[0]);
            acc4      <= mul_step(acc4, mcand, rate4_sh[0]);
            rate16_sh <= rate16_sh >> 1;
            rate4_sh  <= rate4_sh >> 1;
            mcand     <= mcand << 1;
        end else if (state == mbd_ctrl_pkg::EX_SUM && !scores_valid) begin
            scores.score_i16 <= acc16 + disto_term(job_q.c16.disto);
            scores.score_i4  <= acc4 + disto_term(job_q.c4.disto);
        end
    end

    assign job_out = job_q;

endmodule

// File: hdl/mbd_result.sv
`timescale 1ns/1ps

`include "mbd_settings.svh"

module mbd_result (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mbd_data_pkg::mb_scores_t   scores,
    input  mbd_data_pkg::mb_job_t      job,
    input  logic                       scores_valid,
    output mbd_data_pkg::mb_result_t   result,
    output logic                       done
);

    localparam int DC_BIT = `MBD_YNZ_W - 1;

    mbd_ctrl_pkg::mb_type_e    pick;
    logic [`MBD_YNZ_W-1:0]     nz_sel;
    logic [`MBD_SCORE_W-1:0]   score_sel;
    mbd_data_pkg::mb_result_t  result_next;

    // ------------------------------------------------------------------
    // Mode decision
    // ------------------------------------------------------------------

    always_comb begin
        // Ties go to I16
        if (scores.score_i4 >= scores.score_i16) begin
            pick      = mbd_ctrl_pkg::MB_I16;
            nz_sel    = {job.c16.ynz[DC_BIT], job.uvnz, job.c16.ynz[15:0]};
            score_sel = scores.score_i16;
        end else begin
            // No Y2 block in I4 mode
            pick      = mbd_ctrl_pkg::MB_I4;
            nz_sel    = {1'b0, job.uvnz, job.c4.ynz4};
            score_sel = scores.score_i4;
        end

        result_next.x       = job.x;
        result_next.y       = job.y;
        result_next.mb_type = pick;
        result_next.nz      = nz_sel;
        result_next.skipped = (nz_sel == '0);
        result_next.score   = score_sel;
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    // Result holds until the next decision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= scores_valid;
            if (scores_valid) begin
                result <= result_next;
            end
        end
    end

endmodule

// File: hdl/mbd_top.sv
`timescale 1ns/1ps

`include "mbd_settings.svh"

module mbd_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       reload,
    input  logic [`MBD_LAMBDA_W-1:0]   lambda_in,
    input  logic                       start,
    input  logic [`MBD_POS_W-1:0]      x,
    input  logic [`MBD_POS_W-1:0]      y,
    input  mbd_data_pkg::cand16_t      cand16,
    input  mbd_data_pkg::cand4_t       cand4,
    input  logic [`MBD_UVNZ_W-1:0]     uvnz,
    output logic                       busy,
    output logic                       done,
    output mbd_data_pkg::mb_result_t   result
);

    mbd_data_pkg::mb_job_t     job;
    logic                      job_valid;
    logic                      exec_busy;
    mbd_data_pkg::mb_scores_t  scores;
    mbd_data_pkg::mb_job_t     exec_job;
    logic                      scores_valid;

    mbd_decode mbd_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reload    (reload),
        .lambda_in (lambda_in),
        .start     (start),
        .x         (x),
        .y         (y),
        .cand16    (cand16),
        .cand4     (cand4),
        .uvnz      (uvnz),
        .exec_busy (exec_busy),
        .job       (job),
        .job_valid (job_valid)
    );

    mbd_score_exec mbd_score_exec_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .job          (job),
        .job_valid    (job_valid),
        .exec_busy    (exec_busy),
        .scores       (scores),
        .job_out      (exec_job),
        .scores_valid (scores_valid)
    );

    mbd_result mbd_result_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .scores       (scores),
        .job          (exec_job),
        .scores_valid (scores_valid),
        .result       (result),
        .done         (done)
    );

    assign busy = exec_busy;

endmodule

// File: dv/mbd_tb.sv
`timescale 1ns/1ps

`include "mbd_settings.svh"

module mbd_tb;

    localparam int DONE_LAT     = 18;
    localparam int DONE_TIMEOUT = 40;
    // Cycle of the extra start pulsed while busy
    localparam int GHOST_CYCLE  = 5;

    logic                       clk;
    logic                       rst_n;
    logic                       reload;
    logic [`MBD_LAMBDA_W-1:0]   lambda_in;
    logic                       start;
    logic [`MBD_POS_W-1:0]      x;
    logic [`MBD_POS_W-1:0]      y;
    mbd_data_pkg::cand16_t      cand16;
    mbd_data_pkg::cand4_t       cand4;
    logic [`MBD_UVNZ_W-1:0]     uvnz;
    logic                       busy;
    logic                       done;
    mbd_data_pkg::mb_result_t   result;

    logic [15:0]                lfsr_state;
    logic [`MBD_LAMBDA_W-1:0]   lambda_model;
    int                         jobs_run;

    mbd_top mbd_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reload    (reload),
        .lambda_in (lambda_in),
        .start     (start),
        .x         (x),
        .y         (y),
        .cand16    (cand16),
        .cand4     (cand4),
        .uvnz      (uvnz),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input mbd_data_pkg::mb_result_t exp,
                                input mbd_data_pkg::mb_result_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Galois LFSR with taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // Idle gap of 0 to 7 cycles taking one LFSR step per bit
    task automatic draw_gap(output int gap);
        logic [2:0] bits;
        int         i;
        for (i = 0; i < 3; i++) begin
            bits[i]    = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        gap = int'(bits);
    endtask

    // Score is lambda times rate plus distortion times 256
    function automatic mbd_data_pkg::mb_result_t expect_decision(
        input logic [`MBD_LAMBDA_W-1:0] lam,
        input mbd_data_pkg::cand16_t    c16,
        input mbd_data_pkg::cand4_t     c4,
        input logic [`MBD_UVNZ_W-1:0]   uv,
        input logic [`MBD_POS_W-1:0]    px,
        input logic [`MBD_POS_W-1:0]    py
    );
        logic [`MBD_SCORE_W-1:0]  s16;
        logic [`MBD_SCORE_W-1:0]  s4;
        mbd_data_pkg::mb_result_t exp;
        s16 = `MBD_SCORE_W'(lam) * `MBD_SCORE_W'(c16.rate)
            + `MBD_SCORE_W'(c16.disto) * `MBD_SCORE_W'(256);
        s4  = `MBD_SCORE_W'(lam) * `MBD_SCORE_W'(c4.rate)
            + `MBD_SCORE_W'(c4.disto) * `MBD_SCORE_W'(256);
        exp   = '0;
        exp.x = px;
        exp.y = py;
        // Ties keep I16
        if (s4 >= s16) begin
            exp.mb_type = mbd_ctrl_pkg::MB_I16;
            exp.nz      = {c16.ynz[`MBD_YNZ_W-1], uv, c16.ynz[15:0]};
            exp.score   = s16;
        end else begin
            exp.mb_type = mbd_ctrl_pkg::MB_I4;
            exp.nz      = {1'b0, uv, c4.ynz4};
            exp.score   = s4;
        end
        exp.skipped = (exp.nz == '0);
        expect_decision = exp;
    endfunction

    // ------------------------------------------------------------------
    // One macroblock
    // ------------------------------------------------------------------

    // Mode 1 reloads lambda before start and mode 2 together with start
    task automatic run_job(input logic [7:0] mode, input logic [`MBD_LAMBDA_W-1:0] lam,
                           input mbd_data_pkg::cand16_t c16, input mbd_data_pkg::cand4_t c4,
                           input logic [`MBD_UVNZ_W-1:0] uv,
                           input logic [`MBD_POS_W-1:0] px, input logic [`MBD_POS_W-1:0] py);
        mbd_data_pkg::mb_result_t exp;
        int                       n;
        int                       gap;
        logic                     seen;
        lambda_in = lam;
        if (mode == 8'd1) begin
            reload = 1'b1;
            @(negedge clk);
            reload       = 1'b0;
            lambda_model = lam;
        end
        exp = expect_decision(lambda_model, c16, c4, uv, px, py);
        if (mode == 8'd2) begin
            reload       = 1'b1;
            lambda_model = lam;
        end
        start  = 1'b1;
        x      = px;
        y      = py;
        cand16 = c16;
        cand4  = c4;
        uvnz   = uv;
        @(negedge clk);
        start  = 1'b0;
        reload = 1'b0;
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            n++;
            // Start with other data while busy that has to be dropped
            if (n == GHOST_CYCLE) begin
                start  = 1'b1;
                x      = ~px;
                y      = ~py;
                cand16 = ~c16;
                cand4  = ~c4;
                uvnz   = ~uv;
            end else if (n == GHOST_CYCLE + 1) begin
                start = 1'b0;
            end
            check_bit("busy", n < DONE_LAT, busy);
            check_bit("done", n == DONE_LAT, done);
            if (done === 1'b1) begin
                seen = 1'b1;
            end else if (n >= DONE_TIMEOUT) begin
                $display("Timeout: done never came within %0d cycles", DONE_TIMEOUT);
                abort_run();
            end
        end
        check_result("result", exp, result);
        draw_gap(gap);
        repeat (gap) begin
            @(negedge clk);
            check_bit("busy", 1'b0, busy);
            check_bit("done", 1'b0, done);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int                       fd;
        int                       code;
        int                       nf;
        string                    line;
        logic [7:0]               f_mode;
        logic [`MBD_LAMBDA_W-1:0] f_lambda;
        logic [`MBD_DISTO_W-1:0]  f_d16;
        logic [`MBD_RATE_W-1:0]   f_r16;
        logic [`MBD_YNZ_W-1:0]    f_ynz;
        logic [`MBD_DISTO_W-1:0]  f_d4;
        logic [`MBD_RATE_W-1:0]   f_r4;
        logic [`MBD_NZ4_W-1:0]    f_ynz4;
        logic [`MBD_UVNZ_W-1:0]   f_uvnz;
        logic [`MBD_POS_W-1:0]    f_x;
        logic [`MBD_POS_W-1:0]    f_y;
        mbd_data_pkg::cand16_t    c16;
        mbd_data_pkg::cand4_t     c4;
        mbd_data_pkg::mb_result_t zero_result;
        rst_n        = 1'b0;
        reload       = 1'b0;
        lambda_in    = '0;
        start        = 1'b0;
        x            = '0;
        y            = '0;
        cand16       = '0;
        cand4        = '0;
        uvnz         = '0;
        zero_result  = '0;
        lfsr_state   = 16'd28010;
        lambda_model = '0;
        jobs_run     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("done", 1'b0, done);
        check_bit("busy", 1'b0, busy);
        check_result("result", zero_result, result);

        fd = $fopen("dv/mbd_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file dv/mbd_input.txt");
            abort_run();
        end
        code = $fgets(line, fd);
        while (code != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                nf = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_mode, f_lambda,
                             f_d16, f_r16, f_ynz, f_d4, f_r4, f_ynz4, f_uvnz, f_x, f_y);
                if (nf != 11) begin
                    $display("Malformed stimulus line: %s", line);
                    abort_run();
                end
                c16 = {f_d16, f_r16, f_ynz};
                c4  = {f_d4, f_r4, f_ynz4};
                run_job(f_mode, f_lambda, c16, c4, f_uvnz, f_x, f_y);
                jobs_run++;
            end
            code = $fgets(line, fd);
        end
        $fclose(fd);

        // No late done after the last job
        repeat (DONE_TIMEOUT) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
        end
        if (jobs_run == 0) begin
            $display("No macroblocks found in the stimulus file");
            abort_run();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: dv/mbd_input.txt
# mode lambda i16_disto i16_rate i16_ynz i4_disto i4_rate i4_ynz4 uvnz x y (all hex)
# mode 0 keeps lambda, 1 reloads it before start, 2 reloads it with start
1 0040 001000 0200 1000f0f 000e00 0400 00ff 0f 000 000
0 0040 000800 0100 0000001 000900 0080 8001 00 001 000
1 0100 001000 0300 100ffff 001100 0200 ffff ff 002 000
0 0100 002000 0040 0000000 002000 0040 0000 00 003 000
0 0100 000500 0010 0000000 000900 0010 1234 00 004 000
0 0100 000900 0010 1ffffff 000500 0010 0000 00 005 000
0 0100 000300 0020 1000000 000400 0020 00ff 00 006 000
0 0100 000300 0020 0ff0000 000400 0020 0001 00 007 000
2 0001 001000 0800 0000f00 001400 0100 0f0f 3c 008 000
0 beef 001000 0800 0000f00 001400 0100 0f0f 3c 009 000
1 ffff ffffff ffff 1ffffff ffffff ffff ffff ff 3ff 3ff
0 0000 ffffff ffff 0000000 fffffe ffff 0000 00 3fe 3ff
1 0003 000010 8001 0000100 000011 7fff 0010 81 010 020
0 0000 000020 aaaa 1000000 000030 5555 0000 00 011 020
1 0200 00ff00 0123 0001000 00fe00 0456 0800 40 123 045
1 0000 000100 ffff 0000000 000100 0000 0000 00 012 021
2 0080 000200 0010 1000000 000201 0000 0001 00 013 021
0 ffff 000200 0010 1000000 000201 0000 0001 00 014 021
0 1234 abcdef 0f0f 0a5a5a5 123456 f0f0 5a5a a5 200 100
1 7fff 000000 8000 1800000 000000 8000 0000 00 0aa 155
0 7fff 000001 8000 0000000 000000 8001 0000 18 155 0aa

// File: vlog.f
+incdir+hdl
hdl/mbd_data_pkg.sv
hdl/mbd_ctrl_pkg.sv
hdl/mbd_decode.sv
hdl/mbd_score_exec.sv
hdl/mbd_result.sv
hdl/mbd_top.sv
dv/mbd_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module mbd_tb

run: compile
	./obj_dir/Vmbd_tb

clean:
	rm -rf obj_dir
